// File: flist.f
+incdir+.
quad_pkg.sv
quad_config_regs.sv
quad_prefetch_buffer.sv
quad_job_ctrl.sv
quad_conv_engine.sv
quad_top.sv
quad_tb_clock.sv
quad_asserts.sv
quad_tb.sv

// File: Bender.yml
package:
  name: quad

sources:
  - include_dirs:
      - .
    files:
      - quad_pkg.sv
      - quad_config_regs.sv
      - quad_prefetch_buffer.sv
      - quad_job_ctrl.sv
      - quad_conv_engine.sv
      - quad_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - quad_tb_clock.sv
      - quad_asserts.sv
      - quad_tb.sv

// File: quad_tb.sv
`include "quad_consts.svh"

module quad_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_JOBS  = 5;
    // APB cycles spent around one job
    localparam int APB_SETUP = 80;

    // Job shapes where the first job leaves stale pixels behind
    int job_k     [NUM_JOBS] = '{3, 3, 8, 5, 2};
    int job_r     [NUM_JOBS] = '{2, 2, 1, 3, 4};
    int job_c     [NUM_JOBS] = '{3, 3, 4, 2, 4};
    int job_relu  [NUM_JOBS] = '{0, 1, 0, 1, 0};
    int job_extra [NUM_JOBS] = '{2, 0, 0, 0, 0};

    logic               clk_core;
    logic               rst;
    quad_pkg::apb_req_t apb_req;
    quad_pkg::apb_rsp_t apb_rsp;
    logic               job_start;
    logic               job_accept;
    logic               job_complete;
    logic               job_complete_ack;
    logic               pixel_valid;
    logic               pixel_ready;
    quad_pkg::pixel_t   pixel_data;
    logic               result_valid;
    logic               result_ready;
    quad_pkg::result_t  result_data;
    int                 j;

    quad_tb_clock u_clock (
        .clk_core (clk_core),
        .rst      (rst)
    );

    quad_top uut (
        .clk_core         (clk_core),
        .rst              (rst),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .pixel_valid      (pixel_valid),
        .pixel_ready      (pixel_ready),
        .pixel_data       (pixel_data),
        .result_valid     (result_valid),
        .result_ready     (result_ready),
        .result_data      (result_data)
    );

    bind quad_top quad_asserts u_asserts (
        .clk_core         (clk_core),
        .rst              (rst),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .pixel_valid      (pixel_valid),
        .pixel_ready      (pixel_ready),
        .pixel_data       (pixel_data),
        .result_valid     (result_valid),
        .result_ready     (result_ready),
        .result_data      (result_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bus and stream drivers called on a falling edge

    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(negedge clk_core);
        apb_req.penable = 1'b1;
        @(negedge clk_core);
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        apb_transfer(1'b1, addr, data);
    endtask

    task automatic read_reg(input logic [7:0] addr);
        apb_transfer(1'b0, addr, 32'h0);
    endtask

    task automatic configure_job(input int n);
        int i;
        write_reg(8'h00, 32'(job_k[n]));
        write_reg(8'h04, 32'(job_r[n]));
        write_reg(8'h08, 32'(job_c[n]));
        write_reg(8'h0C, 32'(job_relu[n]));
        for (i = 0; i < `QUAD_MAX_KERNEL; i++) begin
            write_reg(8'(8'h10 + 4 * i), $urandom);
        end
        for (i = 0; i < 12; i++) begin
            read_reg(8'(4 * i));
        end
    endtask

    // Illegal writes followed by readback of their targets
    task automatic probe_illegal_writes();
        write_reg(8'h30, 32'h5);
        write_reg(8'h12, 32'h7);
        read_reg(8'h30);
        write_reg(8'h00, 32'd0);
        write_reg(8'h00, 32'd9);
        write_reg(8'h04, 32'd0);
        write_reg(8'h08, 32'd0);
        read_reg(8'h00);
        read_reg(8'h04);
        read_reg(8'h08);
    endtask

    task automatic send_pixels(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            pixel_valid = 1'b1;
            pixel_data  = quad_pkg::pixel_t'($urandom);
            while (!pixel_ready) begin
                @(negedge clk_core);
            end
            @(negedge clk_core);
        end
        pixel_valid = 1'b0;
    endtask

    task automatic run_job(input int n);
        job_start = 1'b1;
        while (!job_accept) begin
            @(negedge clk_core);
        end
        job_start = 1'b0;
        // Config is locked once the job is accepted
        write_reg(8'h00, 32'd4);
        read_reg(8'h00);
        fork
            send_pixels(job_k[n] * job_r[n] * job_c[n] + job_extra[n]);
            begin
                while (!job_complete) begin
                    result_ready = ($urandom_range(3) != 0);
                    @(negedge clk_core);
                end
                result_ready = 1'b0;
            end
        join
        repeat ($urandom_range(2)) @(negedge clk_core);
        job_complete_ack = 1'b1;
        @(negedge clk_core);
        job_complete_ack = 1'b0;
        while (job_complete) begin
            @(negedge clk_core);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control

    initial begin
        void'($urandom(32'hbe6f_e39a));
        apb_req          = '0;
        job_start        = 1'b0;
        job_complete_ack = 1'b0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        result_ready     = 1'b0;
        do begin
            @(posedge clk_core);
        end while (rst);
        @(negedge clk_core);
        for (j = 0; j < NUM_JOBS; j++) begin
            configure_job(j);
            if (j == 0) begin
                probe_illegal_writes();
            end
            run_job(j);
        end
        repeat (4) @(negedge clk_core);
        if (uut.u_asserts.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "A bound assertion failed");
        end
    end

    // Stop at the first failed assertion
    always @(negedge clk_core) begin
        if (uut.u_asserts.fail_count != 0) begin
            $display("Something failed");
            $fatal(1, "A bound assertion failed");
        end
    end

    // Watchdog budget from the job shapes plus config traffic
    initial begin
        int limit;
        limit = APB_SETUP;
        for (int n = 0; n < NUM_JOBS; n++) begin
            limit += job_k[n] * job_r[n] * job_c[n] + job_extra[n] + 50 + APB_SETUP;
        end
        repeat (limit) @(posedge clk_core);
        $display("Something failed");
        $fatal(1, "Timeout, the run did not finish within %0d cycles", limit);
    end

endmodule

// File: quad_asserts.sv
`include "quad_consts.svh"

module quad_asserts (
    input logic               clk_core,
    input logic               rst,
    input quad_pkg::apb_req_t apb_req,
    input quad_pkg::apb_rsp_t apb_rsp,
    input logic               job_start,
    input logic               job_accept,
    input logic               job_complete,
    input logic               job_complete_ack,
    input logic               pixel_valid,
    input logic               pixel_ready,
    input quad_pkg::pixel_t   pixel_data,
    input logic               result_valid,
    input logic               result_ready,
    input quad_pkg::result_t  result_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int                fail_count = 0;
    logic [31:0]       shadow [16];
    logic [15:0]       known;
    logic [15:0]       sums [1024];
    logic              busy_m;
    logic              accept_exp;
    logic              comp_exp;
    logic [3:0]        tap_m;
    logic [15:0]       acc_m;
    logic [15:0]       win_m;
    logic [15:0]       res_cnt;
    logic [15:0]       total;
    logic [15:0]       pix_sum;
    logic [15:0]       exp_sum;
    logic [7:0]        exp_row;
    logic [7:0]        exp_col;
    logic [7:0]        tap_wt;
    logic [31:0]       exp_rd;
    logic [3:0]        idx;
    logic              access;
    logic              mapped;
    logic              field_ok;
    logic              wr_ok;
    logic              xfer;
    quad_pkg::result_t held_q;

    // Signed product by explicit sign extension with 16-bit wrap
    function automatic logic [15:0] tap_product(logic [7:0] pix, logic [7:0] wt, logic relu);
        logic [15:0] pix_ext;
        logic [15:0] wt_ext;
        pix_ext = (relu && pix[7]) ? 16'h0000 : {{8{pix[7]}}, pix};
        wt_ext  = {{8{wt[7]}}, wt};
        return pix_ext * wt_ext;
    endfunction

    // Value a register holds after a legal write
    function automatic logic [31:0] stored_value(logic [3:0] i, logic [31:0] d);
        if (i == 4'd1 || i == 4'd2) begin
            return {24'b0, d[7:0]};
        end else if (i == 4'd3) begin
            return {31'b0, d[0]};
        end else if (i >= 4'd4) begin
            return {{24{d[7]}}, d[7:0]};
        end
        return d;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    assign access = apb_req.psel && apb_req.penable;
    assign idx    = apb_req.paddr[5:2];
    assign mapped = (apb_req.paddr[1:0] == 2'b00) && (apb_req.paddr <= 8'h2C);
    assign xfer   = result_valid && result_ready;

    always_comb begin
        case (idx)
            4'd0:       field_ok = (apb_req.pwdata != 0) && (apb_req.pwdata <= `QUAD_MAX_KERNEL);
            4'd1, 4'd2: field_ok = apb_req.pwdata[7:0] != 8'h00;
            default:    field_ok = 1'b1;
        endcase
    end

    assign wr_ok   = mapped && field_ok && !busy_m;
    assign exp_rd  = shadow[idx];
    assign total   = {8'b0, shadow[1][7:0]} * {8'b0, shadow[2][7:0]};
    assign tap_wt  = shadow[4 + tap_m][7:0];
    assign pix_sum = ((tap_m == 0) ? 16'h0000 : acc_m) +
                     tap_product(pixel_data, tap_wt, shadow[3][0]);
    assign exp_sum = sums[res_cnt[9:0]];
    assign exp_row = 8'(res_cnt / shadow[2][7:0]);
    assign exp_col = 8'(res_cnt % shadow[2][7:0]);

    always_ff @(posedge clk_core) begin
        held_q <= result_data;
        if (rst) begin
            busy_m     <= 1'b0;
            accept_exp <= 1'b0;
            comp_exp   <= 1'b0;
            known      <= '0;
        end else begin
            accept_exp <= job_start && !busy_m;
            comp_exp   <= (xfer && res_cnt == total - 1) || (comp_exp && !job_complete_ack);
            if (access && apb_req.pwrite && wr_ok) begin
                shadow[idx] <= stored_value(idx, apb_req.pwdata);
                known[idx]  <= 1'b1;
            end
            if (xfer) begin
                res_cnt <= res_cnt + 1'b1;
            end
            // Only the pixels of the job's own windows count
            if (busy_m && pixel_valid && pixel_ready && win_m < total) begin
                if (tap_m == shadow[0][3:0] - 1) begin
                    sums[win_m[9:0]] <= pix_sum;
                    win_m            <= win_m + 1'b1;
                    tap_m            <= '0;
                end else begin
                    acc_m <= pix_sum;
                    tap_m <= tap_m + 1'b1;
                end
            end
            if (!busy_m && job_start) begin
                busy_m  <= 1'b1;
                tap_m   <= '0;
                win_m   <= '0;
                res_cnt <= '0;
            end else if (comp_exp && job_complete_ack) begin
                busy_m <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    a_pready: assert property (@(posedge clk_core) disable iff (rst)
        access |-> apb_rsp.pready)
        else begin
            $error("ERR apb_rsp.pready exp 1 got %h", $sampled(apb_rsp.pready));
            fail_count++;
        end

    a_wr_err: assert property (@(posedge clk_core) disable iff (rst)
        access && apb_req.pwrite |-> apb_rsp.pslverr == !wr_ok)
        else begin
            $error("ERR apb_rsp.pslverr exp %h got %h", $sampled(!wr_ok),
                $sampled(apb_rsp.pslverr));
            fail_count++;
        end

    a_rd_err: assert property (@(posedge clk_core) disable iff (rst)
        access && !apb_req.pwrite |-> apb_rsp.pslverr == !mapped)
        else begin
            $error("ERR apb_rsp.pslverr exp %h got %h", $sampled(!mapped),
                $sampled(apb_rsp.pslverr));
            fail_count++;
        end

    a_rd_data: assert property (@(posedge clk_core) disable iff (rst)
        access && !apb_req.pwrite && mapped && known[idx] |-> apb_rsp.prdata == exp_rd)
        else begin
            $error("ERR apb_rsp.prdata exp %h got %h", $sampled(exp_rd),
                $sampled(apb_rsp.prdata));
            fail_count++;
        end

    a_accept: assert property (@(posedge clk_core) disable iff (rst)
        job_accept == accept_exp)
        else begin
            $error("ERR job_accept exp %h got %h", $sampled(accept_exp),
                $sampled(job_accept));
            fail_count++;
        end

    a_complete: assert property (@(posedge clk_core) disable iff (rst)
        job_complete == comp_exp)
        else begin
            $error("ERR job_complete exp %h got %h", $sampled(comp_exp),
                $sampled(job_complete));
            fail_count++;
        end

    a_idle_ready: assert property (@(posedge clk_core) disable iff (rst)
        !busy_m |-> !pixel_ready)
        else begin
            $error("Pixel intake was open while no job was running");
            fail_count++;
        end

    a_count: assert property (@(posedge clk_core) disable iff (rst)
        xfer |-> busy_m && res_cnt < total)
        else begin
            $error("A result arrived beyond the expected count of the job");
            fail_count++;
        end

    a_sum: assert property (@(posedge clk_core) disable iff (rst)
        xfer |-> result_data.sum == exp_sum)
        else begin
            $error("ERR result_data.sum exp %h got %h", $sampled(exp_sum),
                $sampled(result_data.sum));
            fail_count++;
        end

    a_pos: assert property (@(posedge clk_core) disable iff (rst)
        xfer |-> result_data.row == exp_row && result_data.col == exp_col)
        else begin
            $error("ERR result_data.row/col exp %h/%h got %h/%h", $sampled(exp_row),
                $sampled(exp_col), $sampled(result_data.row), $sampled(result_data.col));
            fail_count++;
        end

    // Held result must not move under back-pressure
    a_hold: assert property (@(posedge clk_core) disable iff (rst)
        result_valid && !result_ready |=> result_valid && result_data == held_q)
        else begin
            $error("ERR result_data exp %h got %h", $sampled(held_q),
                $sampled(result_data));
            fail_count++;
        end

endmodule

// File: quad_tb_clock.sv
module quad_tb_clock (
    output logic clk_core,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk_core = 1'b0;
        forever #2 clk_core = ~clk_core;
    end

    // Two rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk_core);
        @(negedge clk_core);
        rst = 1'b0;
    end

endmodule

// File: quad_top.sv
module quad_top (
    input  logic               clk_core,
    input  logic               rst,

    input  quad_pkg::apb_req_t apb_req,
    output quad_pkg::apb_rsp_t apb_rsp,

    input  logic               job_start,
    output logic               job_accept,
    output logic               job_complete,
    input  logic               job_complete_ack,

    input  logic               pixel_valid,
    output logic               pixel_ready,
    input  quad_pkg::pixel_t   pixel_data,

    output logic               result_valid,
    input  logic               result_ready,
    output quad_pkg::result_t  result_data
);

    quad_pkg::layer_cfg_t cfg;
    quad_pkg::pixel_t     head_data;
    logic                 busy;
    logic                 fill_en;
    logic                 job_done;
    logic                 head_valid;
    logic                 head_pop;

    // Layer configuration
    quad_config_regs u_config (
        .clk_core (clk_core),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .busy     (busy),
        .cfg      (cfg)
    );

    // Handshake with the main controller
    quad_job_ctrl u_job_ctrl (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .job_done         (job_done),
        .busy             (busy),
        .fill_en          (fill_en)
    );

    quad_prefetch_buffer u_prefetch (
        .clk_core  (clk_core),
        .rst       (rst),
        .fill_en   (fill_en),
        .in_valid  (pixel_valid),
        .in_ready  (pixel_ready),
        .in_data   (pixel_data),
        .out_valid (head_valid),
        .out_pop   (head_pop),
        .out_data  (head_data)
    );

    quad_conv_engine u_engine (
        .clk_core     (clk_core),
        .rst          (rst),
        .busy         (busy),
        .cfg          (cfg),
        .head_valid   (head_valid),
        .head_data    (head_data),
        .pop          (head_pop),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_data  (result_data),
        .job_done     (job_done)
    );

endmodule

// File: quad_conv_engine.sv
`include "quad_consts.svh"

module quad_conv_engine (
    input  logic                 clk_core,
    input  logic                 rst,
    input  logic                 busy,
    input  quad_pkg::layer_cfg_t cfg,
    input  logic                 head_valid,
    input  quad_pkg::pixel_t     head_data,
    output logic                 pop,
    output logic                 result_valid,
    input  logic                 result_ready,
    output quad_pkg::result_t    result_data,
    output logic                 job_done
);

    localparam int TAP_W = $clog2(`QUAD_MAX_KERNEL + 1);

    logic [TAP_W-1:0]                 tap_q;
    logic signed [`QUAD_RESULT_W-1:0] acc_q;
    logic signed [`QUAD_RESULT_W-1:0] acc_nxt;
    logic signed [`QUAD_RESULT_W-1:0] prod;
    logic signed [`QUAD_WEIGHT_W-1:0] wt;
    quad_pkg::pixel_t                 pix_act;
    logic                             acc_full;
    logic                             windows_done;
    logic [`QUAD_DIM_W-1:0]           row_q;
    logic [`QUAD_DIM_W-1:0]           col_q;
    logic                             last_tap;
    logic                             last_pos;
    logic                             out_free;
    logic                             move;
    logic                             stop;
    logic                             xfer;

    ////////////////////////////////////////////////////////////////////////////
    // Activation and multiply-accumulate

    // ReLU on the buffer head
    assign pix_act = (cfg.relu_en && head_data[`QUAD_PIXEL_W-1]) ? '0 : head_data;
    assign wt      = cfg.weights[tap_q];
    assign prod    = pix_act * wt;

    // First tap restarts the sum, 16-bit wraparound otherwise
    assign acc_nxt  = (tap_q == '0) ? prod : acc_q + prod;
    assign last_tap = tap_q == cfg.kernel_size - 1'b1;

    // Position the window in acc will take when it moves out
    assign last_pos = (row_q == cfg.num_rows - 1'b1) && (col_q == cfg.num_cols - 1'b1);

    // Output register can take a new sum on this edge
    assign out_free = !result_valid || result_ready;
    assign move     = acc_full && out_free;
    assign xfer     = result_valid && result_ready;

    // No pixel beyond the final window of the job
    assign stop = windows_done || (acc_full && last_pos);

    // Stall only when both the output and acc hold finished windows
    assign pop = busy && head_valid && !stop && (!acc_full || move);

    assign job_done = xfer &&
                      (result_data.row == cfg.num_rows - 1'b1) &&
                      (result_data.col == cfg.num_cols - 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // Window tracking and output handshake

    always_ff @(posedge clk_core) begin
        if (rst || !busy) begin
            tap_q        <= '0;
            acc_full     <= 1'b0;
            windows_done <= 1'b0;
            row_q        <= '0;
            col_q        <= '0;
            result_valid <= 1'b0;
        end else begin
            if (pop) begin
                tap_q <= last_tap ? '0 : tap_q + 1'b1;
            end
            acc_full <= (acc_full && !move) || (pop && last_tap);
            if (move) begin
                result_valid <= 1'b1;
                windows_done <= last_pos;
                // Columns step first, then rows
                if (col_q == cfg.num_cols - 1'b1) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end else if (xfer) begin
                result_valid <= 1'b0;
            end
        end
    end

    // Sum and tagged result, loaded by the handshake above
    always_ff @(posedge clk_core) begin
        if (pop) begin
            acc_q <= acc_nxt;
        end
        if (move) begin
            result_data <= '{sum: acc_q, row: row_q, col: col_q};
        end
    end

endmodule

// File: quad_job_ctrl.sv
module quad_job_ctrl (
    input  logic clk_core,
    input  logic rst,
    input  logic job_start,
    output logic job_accept,
    output logic job_complete,
    input  logic job_complete_ack,
    input  logic job_done,
    output logic busy,
    output logic fill_en
);

    quad_pkg::job_state_e state_q;

    ////////////////////////////////////////////////////////////////////////////
    // Job FSM

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state_q      <= quad_pkg::ST_IDLE;
            job_accept   <= 1'b0;
            job_complete <= 1'b0;
        end else begin
            // accept is a single pulse
            job_accept <= 1'b0;
            case (state_q)
                quad_pkg::ST_IDLE: begin
                    if (job_start) begin
                        state_q    <= quad_pkg::ST_ACTIVE;
                        job_accept <= 1'b1;
                    end
                end
                quad_pkg::ST_ACTIVE: begin
                    // Final result has left the engine
                    if (job_done) begin
                        state_q      <= quad_pkg::ST_SEND_COMPLETE;
                        job_complete <= 1'b1;
                    end
                end
                quad_pkg::ST_SEND_COMPLETE: begin
                    // Hold complete until the main controller acks
                    if (job_complete_ack) begin
                        state_q      <= quad_pkg::ST_IDLE;
                        job_complete <= 1'b0;
                    end
                end
                default: begin
                    state_q <= quad_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Config stays locked until the job is fully handed back
    assign busy = state_q != quad_pkg::ST_IDLE;

    // Pixel intake only while the job is running
    assign fill_en = state_q == quad_pkg::ST_ACTIVE;

endmodule

// File: quad_prefetch_buffer.sv
`include "quad_consts.svh"

module quad_prefetch_buffer #(
    parameter int DEPTH = `QUAD_FIFO_DEPTH
) (
    input  logic             clk_core,
    input  logic             rst,
    input  logic             fill_en,
    input  logic             in_valid,
    output logic             in_ready,
    input  quad_pkg::pixel_t in_data,
    output logic             out_valid,
    input  logic             out_pop,
    output quad_pkg::pixel_t out_data
);

    localparam int          AW         = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    quad_pkg::pixel_t mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count_q;
    logic             push;
    logic             pull;

    assign in_ready  = fill_en && (count_q != FULL_COUNT);
    assign out_valid = fill_en && (count_q != '0);
    assign push      = in_valid && in_ready;
    assign pull      = out_pop && out_valid;

    // Head is read straight from storage
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Empty between jobs so old pixels never reach the engine
    always_ff @(posedge clk_core) begin
        if (rst || !fill_en) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: quad_config_regs.sv
`include "quad_consts.svh"

module quad_config_regs (
    input  logic                 clk_core,
    input  logic                 rst,
    input  quad_pkg::apb_req_t   apb_req,
    output quad_pkg::apb_rsp_t   apb_rsp,
    input  logic                 busy,
    output quad_pkg::layer_cfg_t cfg
);

    localparam int WIDX_W = $clog2(`QUAD_MAX_KERNEL);

    quad_pkg::layer_cfg_t        cfg_q;
    quad_pkg::layer_cfg_t        cfg_nxt;
    logic                        access;
    logic                        addr_hit;
    logic                        field_ok;
    logic                        wr_fire;
    logic [31:0]                 rdata;
    logic [`QUAD_APB_ADDR_W-1:0] wt_off;
    logic [WIDX_W-1:0]           wt_idx;
    logic [`QUAD_WEIGHT_W-1:0]   wt_rd;

    // Access phase, no wait states
    assign access = apb_req.psel && apb_req.penable;

    // Weight slot from word offset into the table
    assign wt_off = apb_req.paddr - quad_pkg::REG_WEIGHT0;
    assign wt_idx = wt_off[2 +: WIDX_W];
    assign wt_rd  = cfg_q.weights[wt_idx];

    ////////////////////////////////////////////////////////////////////////////
    // Address decode, range check and next value

    always_comb begin
        addr_hit = 1'b1;
        field_ok = 1'b1;
        rdata    = '0;
        cfg_nxt  = cfg_q;
        case (apb_req.paddr)
            quad_pkg::REG_KERNEL_SIZE: begin
                rdata    = 32'(cfg_q.kernel_size);
                field_ok = (apb_req.pwdata != '0) && (apb_req.pwdata <= `QUAD_MAX_KERNEL);
                cfg_nxt.kernel_size = apb_req.pwdata[$bits(cfg_q.kernel_size)-1:0];
            end
            quad_pkg::REG_NUM_ROWS: begin
                rdata    = 32'(cfg_q.num_rows);
                field_ok = apb_req.pwdata[`QUAD_DIM_W-1:0] != '0;
                cfg_nxt.num_rows = apb_req.pwdata[`QUAD_DIM_W-1:0];
            end
            quad_pkg::REG_NUM_COLS: begin
                rdata    = 32'(cfg_q.num_cols);
                field_ok = apb_req.pwdata[`QUAD_DIM_W-1:0] != '0;
                cfg_nxt.num_cols = apb_req.pwdata[`QUAD_DIM_W-1:0];
            end
            quad_pkg::REG_CTRL: begin
                rdata = {31'b0, cfg_q.relu_en};
                cfg_nxt.relu_en = apb_req.pwdata[0];
            end
            default: begin
                if (apb_req.paddr >= quad_pkg::REG_WEIGHT0 &&
                    apb_req.paddr <= quad_pkg::REG_WEIGHT7 &&
                    apb_req.paddr[1:0] == 2'b00) begin
                    // Weights read back sign-extended
                    rdata = {{(32 - `QUAD_WEIGHT_W){wt_rd[`QUAD_WEIGHT_W-1]}}, wt_rd};
                    cfg_nxt.weights[wt_idx] = apb_req.pwdata[`QUAD_WEIGHT_W-1:0];
                end else begin
                    addr_hit = 1'b0;
                end
            end
        endcase
    end

    // Config is frozen while a job runs
    assign wr_fire = access && apb_req.pwrite && addr_hit && field_ok && !busy;

    assign apb_rsp = '{
        prdata:  (access && !apb_req.pwrite) ? rdata : '0,
        pready:  access,
        pslverr: access && (!addr_hit || (apb_req.pwrite && (!field_ok || busy)))
    };

    always_ff @(posedge clk_core) begin
        if (rst) begin
            cfg_q <= '{kernel_size: 1, num_rows: 1, num_cols: 1, relu_en: 1'b0, weights: '0};
        end else if (wr_fire) begin
            cfg_q <= cfg_nxt;
        end
    end

    assign cfg = cfg_q;

endmodule

// File: quad_pkg.sv
`include "quad_consts.svh"

package quad_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_SEND_COMPLETE
    } job_state_e;

    // Register map, weights sit on consecutive words
    typedef enum logic [`QUAD_APB_ADDR_W-1:0] {
        REG_KERNEL_SIZE = 'h00,
        REG_NUM_ROWS    = 'h04,
        REG_NUM_COLS    = 'h08,
        REG_CTRL        = 'h0C,
        REG_WEIGHT0     = 'h10,
        REG_WEIGHT1     = 'h14,
        REG_WEIGHT2     = 'h18,
        REG_WEIGHT3     = 'h1C,
        REG_WEIGHT4     = 'h20,
        REG_WEIGHT5     = 'h24,
        REG_WEIGHT6     = 'h28,
        REG_WEIGHT7     = 'h2C
    } reg_addr_e;

    typedef struct packed {
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`QUAD_APB_ADDR_W-1:0] paddr;
        logic [31:0]                 pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef logic signed [`QUAD_PIXEL_W-1:0]  pixel_t;
    typedef logic signed [`QUAD_WEIGHT_W-1:0] weight_t;

    typedef struct packed {
        logic [$clog2(`QUAD_MAX_KERNEL + 1)-1:0] kernel_size;
        logic [`QUAD_DIM_W-1:0]                  num_rows;
        logic [`QUAD_DIM_W-1:0]                  num_cols;
        logic                                    relu_en;
        weight_t [`QUAD_MAX_KERNEL-1:0]          weights;
    } layer_cfg_t;

    typedef struct packed {
        logic signed [`QUAD_RESULT_W-1:0] sum;
        logic [`QUAD_DIM_W-1:0]           row;
        logic [`QUAD_DIM_W-1:0]           col;
    } result_t;

endpackage

// File: quad_consts.svh
`ifndef QUAD_CONSTS_SVH
`define QUAD_CONSTS_SVH

// Datapath widths
`define QUAD_PIXEL_W      8
`define QUAD_WEIGHT_W     8
`define QUAD_RESULT_W     16

// Largest kernel, also the size of the weight table
`define QUAD_MAX_KERNEL   8

// Row and column counters
`define QUAD_DIM_W        8

// Config bus
`define QUAD_APB_ADDR_W   8

// Default prefetch depth, keep it a power of two
`define QUAD_FIFO_DEPTH   16

`endif
